/* rtl/piano_pkg.sv */
`default_nettype none

package piano_pkg;

    // Processor control word, first field is the top bit
    typedef struct packed {
        logic       compare_correct;
        logic [5:0] sung_note_id;
        logic [6:0] play_note_id_2;  // Ignored
        logic [6:0] play_note_id_1;  // Ignored
        logic [6:0] play_note_id_0;
        logic [1:0] play_note_num;   // Ignored
        logic [1:0] mode_sel;        // 0 home, 1 ear training, 2 free play
    } gpio_cmd_t;

    typedef logic [3:0] note_idx_t;  // 1 C ... 12 B, 0 none
    typedef logic [7:0] char_t;
    typedef char_t [7:0] display_t;  // Digit 7 leftmost

    typedef struct packed {
        char_t letter;
        char_t accidental;
    } note_chars_t;

    localparam int NOTE_RANGE_OFFSET   = 27;  // Sung range C3 (28) to B3 (39)
    localparam int KEYS_PER_OCTAVE     = 12;
    localparam int FIRST_OCTAVE_OFFSET = 3;

    localparam char_t CH_SPACE  = 8'h20;
    localparam char_t CH_QMARK  = 8'h3F;
    localparam char_t CH_MINUS  = 8'h2D;
    localparam char_t CH_SIX    = 8'h36;
    localparam char_t CH_SQUOTE = 8'h27;
    localparam char_t CH_A = 8'h41;
    localparam char_t CH_B = 8'h42;
    localparam char_t CH_C = 8'h43;
    localparam char_t CH_D = 8'h44;
    localparam char_t CH_E = 8'h45;
    localparam char_t CH_F = 8'h46;
    localparam char_t CH_G = 8'h47;
    localparam char_t CH_H = 8'h48;
    localparam char_t CH_P = 8'h50;
    localparam char_t CH_S = 8'h53;
    localparam char_t CH_T = 8'h54;

    // Spreadsheet note id to index within the sung octave
    function automatic note_idx_t note_from_id(input logic [6:0] id);
        if (id > 7'(NOTE_RANGE_OFFSET) && id <= 7'(NOTE_RANGE_OFFSET + KEYS_PER_OCTAVE))
            return note_idx_t'(id - 7'(NOTE_RANGE_OFFSET));
        return note_idx_t'(0);
    endfunction

    function automatic note_chars_t note_to_chars(input note_idx_t idx);
        case (idx)
            4'd1:    return '{CH_C, CH_SPACE};
            4'd2:    return '{CH_C, CH_SQUOTE};
            4'd3:    return '{CH_D, CH_SPACE};
            4'd4:    return '{CH_D, CH_SQUOTE};
            4'd5:    return '{CH_E, CH_SPACE};
            4'd6:    return '{CH_F, CH_SPACE};
            4'd7:    return '{CH_F, CH_SQUOTE};
            4'd8:    return '{CH_G, CH_SPACE};
            4'd9:    return '{CH_G, CH_SQUOTE};
            4'd10:   return '{CH_A, CH_SPACE};
            4'd11:   return '{CH_A, CH_SQUOTE};
            4'd12:   return '{CH_B, CH_SPACE};
            default: return '{CH_SPACE, CH_SPACE};
        endcase
    endfunction

    // Octave 1 clocks per period at 100 MHz
    function automatic logic [31:0] base_period(input note_idx_t idx);
        case (idx)
            4'd1:    return 32'd3057805;
            4'd2:    return 32'd2886184;
            4'd3:    return 32'd2724194;
            4'd4:    return 32'd2571298;
            4'd5:    return 32'd2426982;
            4'd6:    return 32'd2290765;
            4'd7:    return 32'd2162195;
            4'd8:    return 32'd2040840;
            4'd9:    return 32'd1926296;
            4'd10:   return 32'd1818182;
            4'd11:   return 32'd1716135;
            4'd12:   return 32'd1619816;
            default: return 32'd0;
        endcase
    endfunction

    // Active low, bits g down to a
    function automatic logic [6:0] glyph(input char_t ch);
        case (ch)
            CH_QMARK:  return 7'b0101100;
            CH_MINUS:  return 7'b0111111;
            CH_SIX:    return 7'b0000010;
            CH_SQUOTE: return 7'b1111101;  // Upper right bar only
            CH_A:      return 7'b0001000;
            CH_B:      return 7'b0000011;  // Lower case b
            CH_C:      return 7'b1000110;
            CH_D:      return 7'b0100001;  // Lower case d
            CH_E:      return 7'b0000110;
            CH_F:      return 7'b0001110;
            CH_G:      return 7'b1000010;
            CH_H:      return 7'b0001001;
            CH_P:      return 7'b0001100;
            CH_S:      return 7'b0010010;
            CH_T:      return 7'b0000111;
            default:   return 7'b1111111;
        endcase
    endfunction

endpackage

`default_nettype wire

/* rtl/mode_display.sv */
`timescale 1ns/1ps
`default_nettype none

module mode_display (
    input  wire                    CLK100MHZ,
    input  wire                    CPU_RESETN,
    input  piano_pkg::gpio_cmd_t   cmd,
    input  piano_pkg::note_idx_t   piano_key,
    input  wire [2:0]              octave,
    output piano_pkg::display_t    display,
    output logic                   ear_training_en,
    output logic [6:0]             piano_note_id
);

    logic [1:0]              mode_q;
    logic [5:0]              sung_q;
    piano_pkg::note_idx_t    key_q;
    logic                    changed;
    piano_pkg::note_idx_t    sung_idx;
    piano_pkg::note_chars_t  sung_chars;
    piano_pkg::note_chars_t  key_chars;
    piano_pkg::char_t        compare_char;
    piano_pkg::display_t     display_next;

    // Inputs sampled every cycle and flagged when any of them moved
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            mode_q  <= 2'd0;
            sung_q  <= 6'd0;
            key_q   <= '0;
            changed <= 1'b0;
        end else begin
            mode_q  <= cmd.mode_sel;
            sung_q  <= cmd.sung_note_id;
            key_q   <= piano_key;
            changed <= (cmd.mode_sel != mode_q) || (cmd.sung_note_id != sung_q)
                       || (piano_key != key_q);
        end
    end

    assign ear_training_en = (mode_q == 2'd1);

    assign sung_idx     = piano_pkg::note_from_id({1'b0, sung_q});
    assign sung_chars   = piano_pkg::note_to_chars(sung_idx);
    assign key_chars    = piano_pkg::note_to_chars(key_q);
    assign compare_char = cmd.compare_correct ? piano_pkg::CH_SIX : piano_pkg::CH_MINUS;

    always_comb begin
        display_next    = {8{piano_pkg::CH_SPACE}};
        display_next[3] = compare_char;
        case (mode_q)
            2'd0: begin  // Home screen
                display_next[1] = piano_pkg::CH_H;
                display_next[0] = piano_pkg::CH_S;
            end
            2'd1: begin  // Ear training hides the sung note
                display_next[7] = piano_pkg::CH_QMARK;
                display_next[6] = piano_pkg::CH_QMARK;
                display_next[5] = key_chars.letter;
                display_next[4] = key_chars.accidental;
                display_next[1] = piano_pkg::CH_E;
                display_next[0] = piano_pkg::CH_T;
            end
            2'd2: begin  // Free play
                display_next[7] = sung_chars.letter;
                display_next[6] = sung_chars.accidental;
                display_next[5] = key_chars.letter;
                display_next[4] = key_chars.accidental;
                display_next[1] = piano_pkg::CH_F;
                display_next[0] = piano_pkg::CH_P;
            end
            default: ;  // Blank mode
        endcase
    end

    // Refresh only on a change event
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            display <= {8{piano_pkg::CH_SPACE}};
        end else if (changed) begin
            display <= display_next;
        end
    end

    // Key index back to the processor's global note id
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            piano_note_id <= 7'd0;
        end else if (piano_key == '0) begin
            piano_note_id <= 7'd0;  // No key held
        end else begin
            piano_note_id <= 7'(octave) * 7'(piano_pkg::KEYS_PER_OCTAVE)
                             + 7'(piano_key) + 7'(piano_pkg::FIRST_OCTAVE_OFFSET);
        end
    end

endmodule

`default_nettype wire

/* rtl/seg7_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_scanner #(
    parameter int SCAN_DIV = 100000
) (
    input  wire                  CLK100MHZ,
    input  wire                  CPU_RESETN,
    input  piano_pkg::display_t  display,
    output logic [6:0]           SEG7_SEG,
    output logic [7:0]           SEG7_AN,
    output logic                 SEG7_DP
);

    localparam int CNT_W = $clog2(SCAN_DIV + 1);

    logic [CNT_W-1:0] div_cnt;
    logic [2:0]       digit_sel;

    // Each digit held for SCAN_DIV clocks
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            div_cnt   <= '0;
            digit_sel <= 3'd0;
        end else if (div_cnt == CNT_W'(SCAN_DIV - 1)) begin
            div_cnt   <= '0;
            digit_sel <= digit_sel + 3'd1;  // Wraps 7 to 0
        end else begin
            div_cnt <= div_cnt + CNT_W'(1);
        end
    end

    assign SEG7_AN  = ~(8'b1 << digit_sel);  // Active low
    assign SEG7_SEG = piano_pkg::glyph(display[digit_sel]);
    assign SEG7_DP  = 1'b1;  // Decimal points unused

endmodule

`default_nettype wire

/* rtl/volume_control.sv */
`timescale 1ns/1ps
`default_nettype none

module volume_control (
    input  wire         CLK100MHZ,
    input  wire         CPU_RESETN,
    input  wire         BTNU,
    input  wire         BTND,
    output logic [3:0]  volume
);

    logic up_q;
    logic down_q;
    logic up_rise;
    logic down_rise;

    assign up_rise   = BTNU && !up_q;
    assign down_rise = BTND && !down_q;

    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            up_q   <= 1'b0;
            down_q <= 1'b0;
            volume <= 4'd0;
        end else begin
            up_q   <= BTNU;
            down_q <= BTND;
            if (up_rise) begin  // Up wins when both rise
                if (volume != 4'd15)
                    volume <= volume + 4'd1;
            end else if (down_rise) begin
                if (volume != 4'd0)
                    volume <= volume - 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/tone_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_generator #(
    parameter int PITCH_SHIFT = 3
) (
    input  wire        CLK100MHZ,
    input  wire        CPU_RESETN,
    input  wire [6:0]  play_note_id,
    input  wire [3:0]  volume,
    input  wire        play_en,
    input  wire        ear_training_en,
    output logic       AUD_PWM
);

    piano_pkg::note_idx_t note_idx;
    logic [31:0]          period;
    logic [31:0]          period_q;
    logic [31:0]          period_prev;
    logic                 new_period;
    logic [31:0]          tone_cnt;
    logic [3:0]           frame_cnt;
    logic                 tone_high;
    logic                 vol_on;

    assign note_idx = piano_pkg::note_from_id(play_note_id);
    assign period   = piano_pkg::base_period(note_idx) >> PITCH_SHIFT;  // Zero when no note

    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            period_q    <= 32'd0;
            period_prev <= 32'd0;
        end else begin
            period_q    <= period;
            period_prev <= period_q;
        end
    end

    assign new_period = (period_q != period_prev);

    // Tone counter restarts on a new note or at the end of a period
    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN) begin
            tone_cnt  <= 32'd0;
            frame_cnt <= 4'd0;
        end else begin
            frame_cnt <= frame_cnt + 4'd1;  // 16 cycle volume frame
            if (new_period || (tone_cnt + 32'd1 >= period_q))
                tone_cnt <= 32'd0;
            else
                tone_cnt <= tone_cnt + 32'd1;
        end
    end

    assign tone_high = (tone_cnt < (period_q >> 1));
    assign vol_on    = (frame_cnt < volume);

    always_ff @(posedge CLK100MHZ) begin
        if (!CPU_RESETN)
            AUD_PWM <= 1'b0;
        else
            AUD_PWM <= tone_high && vol_on && play_en && ear_training_en;
    end

endmodule

`default_nettype wire

/* rtl/piano_trainer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module piano_trainer_top #(
    parameter int PITCH_SHIFT = 3,
    parameter int SCAN_DIV    = 100000
) (
    input  wire                    CLK100MHZ,
    input  wire                    CPU_RESETN,
    input  wire [3:0]              playen_oct,
    input  piano_pkg::note_idx_t   piano_key,
    input  wire                    BTNU,
    input  wire                    BTND,
    input  wire [31:0]             axi_swctrl_piano_i,
    output logic [6:0]             piano_note_id,
    output logic                   AUD_SD,
    output logic                   AUD_PWM,
    output logic [15:0]            LED,
    output logic [6:0]             SEG7_SEG,
    output logic [7:0]             SEG7_AN,
    output logic                   SEG7_DP
);

    piano_pkg::gpio_cmd_t cmd;
    piano_pkg::display_t  display;
    logic                 play_en;
    logic [2:0]           octave;
    logic                 ear_training_en;
    logic [3:0]           volume;

    assign cmd     = piano_pkg::gpio_cmd_t'(axi_swctrl_piano_i);
    assign play_en = playen_oct[3];
    assign octave  = playen_oct[2:0];

    assign AUD_SD = play_en;
    assign LED    = {AUD_SD, 14'b0, AUD_PWM};  // Faint glow on bit 0 while the tone plays

    mode_display u_mode_display (
        .CLK100MHZ       (CLK100MHZ),
        .CPU_RESETN      (CPU_RESETN),
        .cmd             (cmd),
        .piano_key       (piano_key),
        .octave          (octave),
        .display         (display),
        .ear_training_en (ear_training_en),
        .piano_note_id   (piano_note_id)
    );

    seg7_scanner #(
        .SCAN_DIV (SCAN_DIV)
    ) u_seg7_scanner (
        .CLK100MHZ  (CLK100MHZ),
        .CPU_RESETN (CPU_RESETN),
        .display    (display),
        .SEG7_SEG   (SEG7_SEG),
        .SEG7_AN    (SEG7_AN),
        .SEG7_DP    (SEG7_DP)
    );

    volume_control u_volume_control (
        .CLK100MHZ  (CLK100MHZ),
        .CPU_RESETN (CPU_RESETN),
        .BTNU       (BTNU),
        .BTND       (BTND),
        .volume     (volume)
    );

    tone_generator #(
        .PITCH_SHIFT (PITCH_SHIFT)
    ) u_tone_generator (
        .CLK100MHZ       (CLK100MHZ),
        .CPU_RESETN      (CPU_RESETN),
        .play_note_id    (cmd.play_note_id_0),
        .volume          (volume),
        .play_en         (play_en),
        .ear_training_en (ear_training_en),
        .AUD_PWM         (AUD_PWM)
    );

endmodule

`default_nettype wire

/* tests/display_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module display_checker #(
    parameter int SCAN_DIV = 4
) (
    input  wire             clk,
    input  wire [6:0]       SEG7_SEG,
    input  wire [7:0]       SEG7_AN,
    input  wire             SEG7_DP,
    input  wire [6:0]       piano_note_id,
    input  wire             AUD_PWM,
    input  wire             AUD_SD,
    input  wire [15:0]      LED,
    input  wire             start,
    input  wire [7:0][6:0]  exp_seg,
    input  wire [6:0]       exp_note_id,
    input  int              exp_pwm_high,
    input  wire             exp_gated,
    input  wire             exp_play_en,
    input  int              window,
    output logic            done,
    output int              seg_errors,
    output int              id_errors,
    output int              pwm_errors,
    output int              scan_errors
);

    // One full digit rotation plus a margin
    task automatic scan_rotation;
        logic [7:0] seen;
        int d;
        seen = '0;
        for (int k = 0; k < 9 * SCAN_DIV; k++) begin
            @(negedge clk);
            d = -1;
            for (int i = 0; i < 8; i++)
                if (SEG7_AN == ~(8'b1 << i))
                    d = i;
            if (d < 0) begin
                $display("At %0t the digit anodes are not one-hot low: %b", $time, SEG7_AN);
                scan_errors++;
            end else begin
                seen[d] = 1'b1;
                if (SEG7_SEG !== exp_seg[d]) begin
                    $display("FAILED %0t SEG7_SEG digit %0d expected %b actual %b",
                             $time, d, exp_seg[d], SEG7_SEG);
                    seg_errors++;
                end
            end
            if (SEG7_DP !== 1'b1) begin
                $display("FAILED %0t SEG7_DP expected 1 actual %b", $time, SEG7_DP);
                seg_errors++;
            end
        end
        if (seen != 8'hFF) begin
            $display("Digits %b were never selected in a full scan rotation", ~seen);
            scan_errors++;
        end
    endtask

    task automatic measure_tone;
        int high;
        int diff;
        high = 0;
        for (int k = 0; k < window; k++) begin
            @(negedge clk);
            if (AUD_PWM === 1'b1)
                high++;
            if (AUD_SD !== exp_play_en || LED[15] !== exp_play_en || LED[0] !== AUD_PWM
                || LED[14:1] !== 14'd0) begin
                $display("FAILED %0t LED expected %b actual %b", $time,
                         {exp_play_en, 14'd0, AUD_PWM}, LED);
                pwm_errors++;
            end
        end
        diff = high - exp_pwm_high;
        if (diff < 0)
            diff = -diff;
        // Silence must be exact, an audible tone gets a frame-alignment margin
        if ((exp_gated && exp_pwm_high > 0) ? (diff > 32) : (high != 0)) begin
            $display("FAILED %0t AUD_PWM high count expected %0d actual %0d",
                     $time, exp_pwm_high, high);
            pwm_errors++;
        end
    endtask

    initial begin
        done = 1'b0;
        {seg_errors, id_errors, pwm_errors, scan_errors} = '0;
        forever begin
            @(negedge clk);
            if (start) begin
                scan_rotation();
                if (piano_note_id !== exp_note_id) begin
                    $display("FAILED %0t piano_note_id expected %0d actual %0d",
                             $time, exp_note_id, piano_note_id);
                    id_errors++;
                end
                measure_tone();
                done = 1'b1;
                while (start) @(negedge clk);
                done = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_piano_trainer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_piano_trainer;

    localparam int PITCH_SHIFT = 10;
    localparam int SCAN_DIV    = 4;
    localparam int ROW_CYCLES  = 120;
    localparam int TONE_WINDOW = 6000;  // Two periods of the lowest note

    typedef struct packed {
        logic [1:0]  mode;
        logic [5:0]  sung;
        logic [6:0]  play;
        logic        cmp;
        logic [3:0]  key;
        logic [2:0]  oct;
        logic        en;
        logic [4:0]  up;
        logic [4:0]  down;
        logic [63:0] exp_chars;  // Digit 7 in the top byte
        logic [6:0]  exp_id;
        logic [3:0]  exp_vol;
    } row_t;

    logic CLK100MHZ;
    logic CPU_RESETN;
    logic [3:0] playen_oct;
    logic [3:0] piano_key;
    logic BTNU;
    logic BTND;
    logic [31:0] axi_swctrl_piano_i;
    logic [6:0] piano_note_id;
    logic AUD_SD;
    logic AUD_PWM;
    logic [15:0] LED;
    logic [6:0] SEG7_SEG;
    logic [7:0] SEG7_AN;
    logic SEG7_DP;

    logic [7:0][6:0] exp_seg;
    logic [6:0] exp_note_id;
    int exp_pwm_high;
    logic exp_gated;
    logic exp_play_en;
    int window;
    logic start;
    logic done;
    int seg_errors;
    int id_errors;
    int pwm_errors;
    int scan_errors;

    row_t rows[0:63];
    int n_rows;
    int cycle_limit;
    int cycles;
    int m_vol;
    logic [1:0] m_mode;
    logic [5:0] m_sung;
    logic [3:0] m_key;
    logic [63:0] m_disp;
    piano_pkg::gpio_cmd_t cmd;

    piano_trainer_top #(.PITCH_SHIFT(PITCH_SHIFT), .SCAN_DIV(SCAN_DIV)) piano_trainer_top_inst (
        .CLK100MHZ(CLK100MHZ), .CPU_RESETN(CPU_RESETN), .playen_oct(playen_oct),
        .piano_key(piano_key), .BTNU(BTNU), .BTND(BTND),
        .axi_swctrl_piano_i(axi_swctrl_piano_i), .piano_note_id(piano_note_id),
        .AUD_SD(AUD_SD), .AUD_PWM(AUD_PWM), .LED(LED), .SEG7_SEG(SEG7_SEG),
        .SEG7_AN(SEG7_AN), .SEG7_DP(SEG7_DP)
    );

    display_checker #(.SCAN_DIV(SCAN_DIV)) checker_inst (
        .clk(CLK100MHZ), .SEG7_SEG(SEG7_SEG), .SEG7_AN(SEG7_AN), .SEG7_DP(SEG7_DP),
        .piano_note_id(piano_note_id), .AUD_PWM(AUD_PWM), .AUD_SD(AUD_SD), .LED(LED),
        .start(start), .exp_seg(exp_seg), .exp_note_id(exp_note_id),
        .exp_pwm_high(exp_pwm_high), .exp_gated(exp_gated), .exp_play_en(exp_play_en),
        .window(window), .done(done), .seg_errors(seg_errors), .id_errors(id_errors),
        .pwm_errors(pwm_errors), .scan_errors(scan_errors)
    );

    initial begin
        CLK100MHZ = 1'b0;
        forever #5 CLK100MHZ = ~CLK100MHZ;
    end

    // Only ids 28 to 39 name a note
    function automatic logic [3:0] id_to_idx(input int id);
        return (id >= 28 && id <= 39) ? 4'(id - 27) : 4'd0;
    endfunction

    function automatic logic [15:0] name_pair(input logic [3:0] idx);
        string letters;
        logic [12:1] sharp;
        letters = "CCDDEFFGGAAB";
        sharp   = 12'b010101001010;
        if (idx < 1 || idx > 12)
            return {" ", " "};
        return {letters[idx - 1], sharp[idx] ? "'" : " "};
    endfunction

    function automatic logic [63:0] build_display(input logic [1:0] mode, input logic [5:0] sung,
                                                  input logic [3:0] key, input logic cmp);
        logic [7:0][7:0] d;
        d    = {8{" "}};
        d[3] = cmp ? "6" : "-";
        case (mode)
            2'd0: {d[1], d[0]} = "HS";
            2'd1: {d[7], d[6], d[5], d[4], d[1], d[0]} = {"??", name_pair(key), "ET"};
            2'd2: {d[7], d[6], d[5], d[4], d[1], d[0]} =
                      {name_pair(id_to_idx(sung)), name_pair(key), "FP"};
            default: ;
        endcase
        return d;
    endfunction

    function automatic logic [6:0] seg_of(input logic [7:0] ch);
        case (ch)
            "?": return 7'b0101100;
            "-": return 7'b0111111;
            "6": return 7'b0000010;
            "'": return 7'b1111101;
            "A": return 7'b0001000;
            "B": return 7'b0000011;
            "C": return 7'b1000110;
            "D": return 7'b0100001;
            "E": return 7'b0000110;
            "F": return 7'b0001110;
            "G": return 7'b1000010;
            "H": return 7'b0001001;
            "P": return 7'b0001100;
            "S": return 7'b0010010;
            "T": return 7'b0000111;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic int tone_period(input int id);
        int table_c[1:12];
        table_c = '{3057805, 2886184, 2724194, 2571298, 2426982, 2290765,
                    2162195, 2040840, 1926296, 1818182, 1716135, 1619816};
        if (id_to_idx(id) == 0)
            return 0;
        return table_c[id_to_idx(id)] >> PITCH_SHIFT;
    endfunction

    task automatic add_row(input int mode, input int sung, input int play, input int cmp,
                           input int key, input int oct, input int en, input int up,
                           input int down);
        row_t r;
        r = '{mode: 2'(mode), sung: 6'(sung), play: 7'(play), cmp: 1'(cmp), key: 4'(key),
              oct: 3'(oct), en: 1'(en), up: 5'(up), down: 5'(down), default: '0};
        for (int i = 0; i < up || i < down; i++) begin
            if (i < up)
                m_vol = (m_vol < 15) ? m_vol + 1 : 15;  // Up wins
            else
                m_vol = (m_vol > 0) ? m_vol - 1 : 0;
        end
        if (r.mode != m_mode || r.sung != m_sung || r.key != m_key)
            m_disp = build_display(r.mode, r.sung, r.key, r.cmp);
        {m_mode, m_sung, m_key} = {r.mode, r.sung, r.key};
        r.exp_chars = m_disp;
        r.exp_id    = (key == 0) ? 7'd0 : 7'(oct * 12 + key + 3);
        r.exp_vol   = 4'(m_vol);
        rows[n_rows] = r;
        n_rows++;
    endtask

    initial begin
        {m_vol, n_rows} = '0;
        {m_mode, m_sung, m_key} = '0;
        m_disp = {8{" "}};
        add_row(1, 30, 28, 0, 1, 2, 1, 8, 0);
        add_row(1, 30, 28, 0, 2, 2, 1, 20, 0);   // Saturates at 15
        add_row(1, 30, 28, 0, 3, 2, 1, 0, 20);   // Down to 0
        add_row(1, 30, 32, 0, 5, 2, 1, 4, 0);
        add_row(1, 30, 32, 0, 5, 2, 1, 2, 2);    // Both pressed
        add_row(1, 30, 32, 0, 6, 1, 0, 0, 0);    // play_en low
        add_row(0, 30, 32, 0, 6, 1, 1, 0, 0);    // Home screen without tone
        for (int i = 0; i < 12; i++)
            add_row(2, 28 + i, 32, i % 2, i + 1, i % 8, 1, 0, 0);
        add_row(2, 20, 28, 0, 0, 4, 1, 0, 0);
        add_row(2, 45, 28, 0, 13, 4, 1, 0, 0);
        add_row(3, 45, 28, 0, 13, 4, 1, 0, 0);
        add_row(3, 45, 28, 1, 13, 4, 1, 0, 0);   // Compare alone
        add_row(1, 45, 28, 1, 13, 4, 1, 0, 0);
        add_row(1, 45, 28, 0, 13, 4, 1, 0, 0);
        add_row(2, 39, 28, 0, 12, 5, 1, 0, 0);
        cycle_limit = n_rows * (ROW_CYCLES + TONE_WINDOW) + 1000;
    end

    initial begin
        cycles = 0;
        @(posedge CLK100MHZ);
        while (cycles < cycle_limit) begin
            @(posedge CLK100MHZ);
            cycles++;
        end
        $display("Timeout after %0d cycles, the checker never finished", cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h59632e5d));
        CPU_RESETN         <= 1'b0;
        playen_oct         <= 4'd0;
        piano_key          <= 4'd0;
        BTNU               <= 1'b0;
        BTND               <= 1'b0;
        axi_swctrl_piano_i <= 32'd0;
        start              <= 1'b0;
        {exp_seg, exp_note_id, exp_pwm_high, exp_gated, exp_play_en, window} <= '0;
        repeat (5) @(posedge CLK100MHZ);
        CPU_RESETN <= 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            @(posedge CLK100MHZ);
            cmd = '{compare_correct: rows[r].cmp, sung_note_id: rows[r].sung,
                    play_note_id_2: 7'($urandom), play_note_id_1: 7'($urandom),
                    play_note_id_0: rows[r].play, play_note_num: 2'($urandom),
                    mode_sel: rows[r].mode};
            axi_swctrl_piano_i <= cmd;
            piano_key  <= rows[r].key;
            playen_oct <= {rows[r].en, rows[r].oct};
            for (int i = 0; i < rows[r].up || i < rows[r].down; i++) begin
                @(posedge CLK100MHZ);
                BTNU <= (i < rows[r].up);
                BTND <= (i < rows[r].down);
                @(posedge CLK100MHZ);
                {BTNU, BTND} <= 2'b00;
            end
            repeat (10) @(posedge CLK100MHZ);
            for (int d = 0; d < 8; d++)
                exp_seg[d] <= seg_of(rows[r].exp_chars[8*d +: 8]);
            exp_note_id  <= rows[r].exp_id;
            exp_play_en  <= rows[r].en;
            exp_gated    <= (rows[r].mode == 2'd1) && rows[r].en;
            exp_pwm_high <= ((rows[r].mode == 2'd1) && rows[r].en)
                            ? tone_period(rows[r].play) * rows[r].exp_vol / 16 : 0;
            window       <= (tone_period(rows[r].play) > 0)
                            ? 2 * tone_period(rows[r].play) : 256;
            start        <= 1'b1;
            @(posedge CLK100MHZ);
            while (!done) @(posedge CLK100MHZ);
            start <= 1'b0;
            @(posedge CLK100MHZ);
            while (done) @(posedge CLK100MHZ);
        end
        $display("Errors: segment %0d, note id %0d, audio %0d, scan %0d",
                 seg_errors, id_errors, pwm_errors, scan_errors);
        if (seg_errors + id_errors + pwm_errors + scan_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/piano_pkg.sv
rtl/mode_display.sv
rtl/seg7_scanner.sv
rtl/volume_control.sv
rtl/tone_generator.sv
rtl/piano_trainer_top.sv
tests/display_checker.sv
tests/tb_piano_trainer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the piano trainer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_piano_trainer -o sim_tb \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited abnormally"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "Result: FAIL"; exit 1; } \
    || grep -q "All checks passed" sim.log \
    || { echo "Result: no verdict in log"; exit 1; }
echo "Result: PASS"
